//--- logic/sb_pkg.sv
package sb_pkg;

  // port counts
  localparam int NUM_READ = 4;
  localparam int NUM_LANE = 2;

  // architectural register file
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REG = 1 << REG_ADDR_W;

  // issue-group id and rename tag widths
  localparam int TID_W = 3;
  localparam int TAG_W = TID_W + 1;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // id 0 marks a register with no pending producer
  typedef logic [TID_W-1:0] tid_t;

  // group id in the upper bits, lane bit at the bottom
  typedef logic [TAG_W-1:0] tag_t;

  // group ids run from 1 up to all ones and wrap back to 1
  localparam tid_t TID_FIRST = tid_t'(1);
  localparam tid_t TID_LAST = '1;

  // one issue cycle from the issuer
  typedef struct packed {
    logic [NUM_LANE-1:0] valid;
    reg_addr_t [NUM_LANE-1:0] dst;
  } issue_req_t;

  // one writeback cycle
  // both lanes always belong to the same group
  typedef struct packed {
    logic [NUM_LANE-1:0] valid;
    reg_addr_t [NUM_LANE-1:0] dst;
    tid_t id;
  } wb_req_t;

  // operand status for the four source reads
  typedef struct packed {
    tag_t [NUM_READ-1:0] tag;
    logic [NUM_READ-1:0] ready;
  } read_rsp_t;

endpackage

//--- logic/reg_board.sv
module reg_board #(
  parameter type entry_t = logic [sb_pkg::TAG_W-1:0]
) (
  input  logic                                       clk,
  input  logic                                       rst_n,

  // read side
  input  sb_pkg::reg_addr_t [sb_pkg::NUM_READ-1:0]   rd_addr_i,
  output entry_t [sb_pkg::NUM_READ-1:0]              rd_data_o,

  // write side
  input  logic [sb_pkg::NUM_LANE-1:0]                wr_en_i,
  input  sb_pkg::reg_addr_t [sb_pkg::NUM_LANE-1:0]   wr_addr_i,
  input  entry_t [sb_pkg::NUM_LANE-1:0]              wr_data_i
);

  import sb_pkg::*;

  // no storage behind register 0
  entry_t mem_q [1:NUM_REG-1];

  logic [NUM_LANE-1:0] wr_ok;

  // writes to register 0 are dropped here and nowhere else
  always_comb begin
    for (int l = 0; l < NUM_LANE; l++) begin
      wr_ok[l] = wr_en_i[l] && (wr_addr_i[l] != '0);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int r = 1; r < NUM_REG; r++) begin
        mem_q[r] <= '0;
      end
    end else begin
      // lanes in ascending order
      // lane 1 lands last when both hit one index
      for (int l = 0; l < NUM_LANE; l++) begin
        if (wr_ok[l]) begin
          mem_q[wr_addr_i[l]] <= wr_data_i[l];
        end
      end
    end
  end

  // reads see the table as it was before this cycle's writes
  always_comb begin
    for (int p = 0; p < NUM_READ; p++) begin
      if (rd_addr_i[p] == '0) begin
        rd_data_o[p] = '0;
      end else begin
        rd_data_o[p] = mem_q[rd_addr_i[p]];
      end
    end
  end

endmodule

//--- logic/tag_counter.sv
module tag_counter (
  input  logic         clk,
  input  logic         rst_n,

  // any lane issuing this cycle
  input  logic         advance_i,

  // id handed to the group issuing now
  output sb_pkg::tid_t cur_id_o,
  // id of the youngest group already issued
  output sb_pkg::tid_t last_id_o
);

  import sb_pkg::*;

  tid_t id_q;
  tid_t id_next;

  // step through 1..7, 0 stays reserved
  always_comb begin
    id_next = id_q;
    if (advance_i) begin
      if (id_q == TID_LAST) begin
        id_next = TID_FIRST;
      end else begin
        id_next = tid_t'(id_q + 1'b1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_q <= TID_FIRST;
    end else begin
      id_q <= id_next;
    end
  end

  assign cur_id_o = id_q;

  // predecessor in the same cycle, 7 right after reset
  assign last_id_o = (id_q == TID_FIRST) ? TID_LAST : tid_t'(id_q - 1'b1);

endmodule

//--- logic/flush_fsm.sv
module flush_fsm (
  input  logic            clk,
  input  logic            rst_n,

  // one-cycle flush pulse from the pipeline
  input  logic            invalidate_i,

  // youngest issued group, from the tag counter
  input  sb_pkg::tid_t    target_id_i,

  // writeback stage
  input  sb_pkg::wb_req_t wb_i,

  output logic            issue_ready_o
);

  typedef enum logic {
    RUN,
    DRAIN
  } state_e;

  state_e state_q;
  state_e state_d;

  logic tgt_hit;

  // issue is blocked in DRAIN, so the counter is frozen from the first
  // DRAIN cycle on and an issue in the invalidate cycle is already counted
  assign tgt_hit = (|wb_i.valid) && (wb_i.id == target_id_i);

  always_comb begin
    state_d = state_q;
    case (state_q)
      RUN: begin
        if (invalidate_i) begin
          state_d = DRAIN;
        end
      end
      DRAIN: begin
        // a fresh flush keeps us waiting
        if (!invalidate_i && tgt_hit) begin
          state_d = RUN;
        end
      end
      default: begin
        state_d = RUN;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= RUN;
    end else begin
      state_q <= state_d;
    end
  end

  assign issue_ready_o = (state_q == RUN);

endmodule

//--- logic/scoreboard.sv
module scoreboard (
  input  logic                                      clk,
  input  logic                                      rst_n,

  // flush control
  input  logic                                      invalidate_i,
  output logic                                      issue_ready_o,

  // source operand lookup
  input  sb_pkg::reg_addr_t [sb_pkg::NUM_READ-1:0]  rd_addr_i,
  output sb_pkg::read_rsp_t                         rd_rsp_o,

  // destination allocation
  // issuer guarantees no conflicting pair in one group
  input  sb_pkg::issue_req_t                        issue_i,
  output sb_pkg::tid_t                              is_w_id_o,

  // writeback
  input  sb_pkg::wb_req_t                           wb_i
);

  import sb_pkg::*;

  tid_t cur_id;
  tid_t last_id;

  // per-lane write data for both boards
  tag_t [NUM_LANE-1:0] is_w_tag;
  tid_t [NUM_LANE-1:0] wb_w_id;

  // raw board outputs at the four read addresses
  tag_t [NUM_READ-1:0] rd_tag;
  tid_t [NUM_READ-1:0] rd_cmt_id;

  // one counter shared by both lanes
  tag_counter u_tags (
    .clk       (clk),
    .rst_n     (rst_n),
    .advance_i (|issue_i.valid),
    .cur_id_o  (cur_id),
    .last_id_o (last_id)
  );

  assign is_w_id_o = cur_id;

  flush_fsm u_flush (
    .clk           (clk),
    .rst_n         (rst_n),
    .invalidate_i  (invalidate_i),
    .target_id_i   (last_id),
    .wb_i          (wb_i),
    .issue_ready_o (issue_ready_o)
  );

  // lane bit tells the two halves of a group apart
  for (genvar l = 0; l < NUM_LANE; l++) begin : g_lane_tag
    assign is_w_tag[l] = {cur_id, 1'(l)};
  end

  // the whole group writes back under one id
  assign wb_w_id = {NUM_LANE{wb_i.id}};

  // last tag issued per register
  reg_board #(
    .entry_t (tag_t)
  ) u_issue_board (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_addr_i (rd_addr_i),
    .rd_data_o (rd_tag),
    .wr_en_i   (issue_i.valid),
    .wr_addr_i (issue_i.dst),
    .wr_data_i (is_w_tag)
  );

  // last group id committed per register
  reg_board #(
    .entry_t (tid_t)
  ) u_commit_board (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_addr_i (rd_addr_i),
    .rd_data_o (rd_cmt_id),
    .wr_en_i   (wb_i.valid),
    .wr_addr_i (wb_i.dst),
    .wr_data_i (wb_w_id)
  );

  // ready once the producing group has committed
  // lane bit is left out of the compare
  always_comb begin
    for (int p = 0; p < NUM_READ; p++) begin
      rd_rsp_o.tag[p] = rd_tag[p];
      rd_rsp_o.ready[p] = (rd_tag[p][TAG_W-1:1] == rd_cmt_id[p]);
    end
  end

endmodule

//--- test/scoreboard_assertions.sv
module scoreboard_assertions (
  input logic                                     clk,
  input logic                                     rst_n,
  input logic                                     invalidate_i,
  input logic                                     issue_ready_o,
  input sb_pkg::tid_t                             is_w_id_o,
  input sb_pkg::reg_addr_t [sb_pkg::NUM_READ-1:0] rd_addr_i,
  input sb_pkg::read_rsp_t                        rd_rsp_o
);

  import sb_pkg::*;

  // id 0 is reserved for registers without a producer
  a_id_nonzero: assert property (@(posedge clk) disable iff (!rst_n) is_w_id_o != '0)
    else $error("is_w_id_o is zero");

  // a flush blocks issue from the next cycle on
  a_flush_blocks: assert property (@(posedge clk) disable iff (!rst_n)
    invalidate_i |=> !issue_ready_o)
    else $error("issue_ready_o high in the cycle after invalidate_i");

  for (genvar p = 0; p < NUM_READ; p++) begin : g_reg0
    a_reg0_free: assert property (@(posedge clk) disable iff (!rst_n)
      rd_addr_i[p] == '0 |-> rd_rsp_o.tag[p] == '0 && rd_rsp_o.ready[p])
      else $error("read port %0d of register 0 is not free", p);
  end

endmodule

bind scoreboard scoreboard_assertions u_assertions (
  .clk           (clk),
  .rst_n         (rst_n),
  .invalidate_i  (invalidate_i),
  .issue_ready_o (issue_ready_o),
  .is_w_id_o     (is_w_id_o),
  .rd_addr_i     (rd_addr_i),
  .rd_rsp_o      (rd_rsp_o)
);

//--- test/scoreboard_tb.sv
module scoreboard_tb;

  import sb_pkg::*;

  // expected DUT outputs for one cycle
  typedef struct packed {
    read_rsp_t rsp;
    tid_t id;
    logic ready;
  } expect_t;

  logic clk;
  logic rst_n;
  logic invalidate;
  logic issue_ready;
  reg_addr_t [NUM_READ-1:0] rd_addr;
  read_rsp_t rd_rsp;
  issue_req_t issue;
  tid_t is_w_id;
  wb_req_t wb;

  // shadow state of the reference model
  tag_t m_tag [NUM_REG];
  tid_t m_cmt [NUM_REG];
  tid_t m_id;
  tid_t m_last;
  tid_t m_target;
  logic m_drain;
  expect_t exp_out;

  string cur_test;
  int total_errs = 0;
  int errs_at_start;
  int tests_run;
  int tests_failed;
  integer seed;

  scoreboard i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .invalidate_i  (invalidate),
    .issue_ready_o (issue_ready),
    .rd_addr_i     (rd_addr),
    .rd_rsp_o      (rd_rsp),
    .issue_i       (issue),
    .is_w_id_o     (is_w_id),
    .wb_i          (wb)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  function automatic issue_req_t make_issue(input logic [NUM_LANE-1:0] v,
                                            input reg_addr_t d1, input reg_addr_t d0);
    issue_req_t r;
    r.valid = v;
    r.dst[1] = d1;
    r.dst[0] = d0;
    return r;
  endfunction

  function automatic wb_req_t make_wb(input logic [NUM_LANE-1:0] v, input reg_addr_t d1,
                                      input reg_addr_t d0, input tid_t id);
    wb_req_t r;
    r.valid = v;
    r.dst[1] = d1;
    r.dst[0] = d0;
    r.id = id;
    return r;
  endfunction

  function automatic void model_reset();
    for (int r = 0; r < NUM_REG; r++) begin
      m_tag[r] = '0;
      m_cmt[r] = '0;
    end
    m_id = 3'd1;
    m_last = 3'd7;
    m_target = 3'd7;
    m_drain = 1'b0;
  endfunction

  // outputs come from the state before this cycle, then the state moves on
  function automatic expect_t sb_model(input reg_addr_t [NUM_READ-1:0] addr,
                                       input issue_req_t iss, input wb_req_t w,
                                       input logic inv);
    expect_t e;
    tag_t t;
    tid_t c;
    for (int p = 0; p < NUM_READ; p++) begin
      t = m_tag[addr[p]];
      c = m_cmt[addr[p]];
      e.rsp.tag[p] = t;
      e.rsp.ready[p] = (t[TAG_W-1:1] == c);
    end
    e.id = m_id;
    e.ready = !m_drain;
    // the youngest group counts even when it issues with the flush
    if (!m_drain && inv) begin
      m_drain = 1'b1;
      m_target = (|iss.valid) ? m_id : m_last;
    end else if (m_drain && !inv && (|w.valid) && w.id == m_target) begin
      m_drain = 1'b0;
    end
    // register 0 keeps no state, lane 1 lands last
    for (int l = 0; l < NUM_LANE; l++) begin
      if (iss.valid[l] && iss.dst[l] != '0) begin
        m_tag[iss.dst[l]] = {m_id, 1'(l)};
      end
      if (w.valid[l] && w.dst[l] != '0) begin
        m_cmt[w.dst[l]] = w.id;
      end
    end
    if (|iss.valid) begin
      m_last = m_id;
      m_id = (m_id == 3'd7) ? 3'd1 : m_id + 3'd1;
    end
    return e;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    if (act !== exp) begin
      $display("** Error: %s: %s expected %0h, actual %0h", cur_test, what, exp, act);
      total_errs++;
    end
  endtask

  // compare half a cycle after each rising edge
  always @(negedge clk) begin
    if (rst_n !== 1'b1) begin
      model_reset();
    end else begin
      exp_out = sb_model(rd_addr, issue, wb, invalidate);
      check_value("rd_rsp_o.tag", 32'(exp_out.rsp.tag), 32'(rd_rsp.tag));
      check_value("rd_rsp_o.ready", 32'(exp_out.rsp.ready), 32'(rd_rsp.ready));
      check_value("is_w_id_o", 32'(exp_out.id), 32'(is_w_id));
      check_value("issue_ready_o", 32'(exp_out.ready), 32'(issue_ready));
    end
  end

  task automatic step_cycle(input reg_addr_t [NUM_READ-1:0] a, input issue_req_t i,
                            input wb_req_t w, input logic inv);
    @(posedge clk);
    rd_addr <= a;
    issue <= i;
    wb <= w;
    invalidate <= inv;
    @(negedge clk);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    issue <= '0;
    wb <= '0;
    invalidate <= 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
  endtask

  task automatic wait_issue_ready(input int max_cycles, input bit sweep);
    wb_req_t w;
    int waited;
    waited = 0;
    while (!issue_ready && waited < max_cycles) begin
      // sweep commits every group id on register 1
      w = sweep ? make_wb(2'b01, 5'd0, 5'd1, tid_t'(waited % 7 + 1)) : '0;
      step_cycle(rd_addr, '0, w, 1'b0);
      waited++;
    end
    if (!issue_ready) begin
      $display("timeout in %s: issue_ready_o low for %0d cycles", cur_test, waited);
      $display("Some tests failed");
      $finish;
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    errs_at_start = total_errs;
  endtask

  task automatic finish_test();
    // the compare process sees the last cycle first
    @(posedge clk);
    tests_run++;
    if (total_errs == errs_at_start) begin
      $display("test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", cur_test, total_errs - errs_at_start);
    end
  endtask

  initial begin
    issue_req_t iss;
    wb_req_t w;
    logic [31:0] r0;
    logic [31:0] r1;
    logic may_issue;
    seed = 86904;
    rst_n = 1'b0;
    invalidate = 1'b0;
    rd_addr = '0;
    issue = '0;
    wb = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    start_test("reset_state");
    for (int r = 0; r < NUM_REG; r += NUM_READ) begin
      step_cycle({reg_addr_t'(r + 3), reg_addr_t'(r + 2), reg_addr_t'(r + 1), reg_addr_t'(r)},
                 '0, '0, 1'b0);
    end
    finish_test();

    // group 1 on lane 1, a stale commit, then the matching one
    start_test("issue_commit");
    step_cycle({5'd0, {3{5'd9}}}, make_issue(2'b10, 5'd9, 5'd0), '0, 1'b0);
    step_cycle(rd_addr, '0, '0, 1'b0);
    step_cycle(rd_addr, '0, make_wb(2'b01, 5'd0, 5'd9, 3'd2), 1'b0);
    step_cycle(rd_addr, '0, '0, 1'b0);
    step_cycle(rd_addr, '0, make_wb(2'b10, 5'd9, 5'd0, 3'd1), 1'b0);
    step_cycle(rd_addr, '0, '0, 1'b0);
    finish_test();

    start_test("reg_zero");
    step_cycle({5'd0, 5'd12, 5'd0, 5'd0}, make_issue(2'b11, 5'd12, 5'd0),
               make_wb(2'b11, 5'd0, 5'd0, 3'd5), 1'b0);
    step_cycle(rd_addr, make_issue(2'b11, 5'd0, 5'd0), '0, 1'b0);
    step_cycle(rd_addr, '0, '0, 1'b0);
    finish_test();

    start_test("id_wrap");
    apply_reset();
    for (int i = 0; i < 8; i++) begin
      step_cycle({5'd4, 5'd3, 5'd2, 5'd1}, make_issue(2'b01, 5'd0, reg_addr_t'(i + 1)), '0,
                 1'b0);
    end
    step_cycle(rd_addr, '0, '0, 1'b0);
    finish_test();

    start_test("flush_drain");
    apply_reset();
    for (int g = 1; g <= 3; g++) begin
      step_cycle({5'd8, 5'd7, 5'd6, 5'd5}, make_issue(2'b01, 5'd0, reg_addr_t'(g + 4)), '0,
                 1'b0);
    end
    // group 4 shares its cycle with the flush
    step_cycle(rd_addr, make_issue(2'b10, 5'd8, 5'd0), '0, 1'b1);
    for (int g = 1; g <= 3; g++) begin
      step_cycle(rd_addr, '0, make_wb(2'b01, 5'd0, reg_addr_t'(g + 4), tid_t'(g)), 1'b0);
    end
    step_cycle(rd_addr, '0, make_wb(2'b10, 5'd8, 5'd0, 3'd4), 1'b0);
    wait_issue_ready(4, 1'b0);
    finish_test();

    start_test("random_traffic");
    for (int n = 0; n < 300; n++) begin
      // RUN without a flush now means RUN in the next cycle
      may_issue = issue_ready && !invalidate;
      r0 = $random(seed);
      r1 = $random(seed);
      iss.valid = may_issue ? r0[21:20] : 2'b00;
      iss.dst = r0[31:22];
      w.valid = r1[1:0];
      w.dst = r1[11:2];
      w.id = r1[14:12] % 3'd7 + 3'd1;
      step_cycle(r0[19:0], iss, w, may_issue && r1[19:16] == 4'd0);
    end
    wait_issue_ready(20, 1'b1);
    step_cycle(rd_addr, '0, '0, 1'b0);
    finish_test();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
    if (tests_failed == 0 && total_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- scoreboard.f
logic/sb_pkg.sv
logic/reg_board.sv
logic/tag_counter.sv
logic/flush_fsm.sv
logic/scoreboard.sv
test/scoreboard_assertions.sv
test/scoreboard_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= scoreboard_tb
FLIST     ?= scoreboard.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All tests passed

.PHONY: all build run clean

all: run

# compile and link the simulator
build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# run, show the output and fail unless the pass line is present
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
